// ==== include/id_macros.svh ====
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define WORD_W    32
`define REG_AW    5
`define NUM_REGS  32
`define LINK_REG  5'd31
`define PC_STEP   4

// primary opcodes
`define OP_SPECIAL 6'h00
`define OP_REGIMM  6'h01
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_SLTIU   6'h0b
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// SPECIAL funct field
`define FN_SLL     6'h00
`define FN_SRL     6'h02
`define FN_SRA     6'h03
`define FN_JR      6'h08
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_NOR     6'h27
`define FN_SLT     6'h2a
`define FN_SLTU    6'h2b

`define RT_BLTZ    5'd0
`define RT_BGEZ    5'd1

`endif

// ==== hdl/id_pkg.sv ====
`include "id_macros.svh"

package id_pkg;

    // one fetched word, three views of it
    typedef union packed {
        struct packed {
            logic [5:0]         opcode;
            logic [`REG_AW-1:0] rs;
            logic [`REG_AW-1:0] rt;
            logic [`REG_AW-1:0] rd;
            logic [4:0]         shamt;
            logic [5:0]         funct;
        } r_fmt;
        struct packed {
            logic [5:0]         opcode;
            logic [`REG_AW-1:0] rs;
            logic [`REG_AW-1:0] rt;
            logic [15:0]        imm;
        } i_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index;
        } j_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS,
        SRC_A_PC,
        SRC_A_SHAMT     // sll/srl/sra shift amount
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_RT,
        SRC_B_SIMM,
        SRC_B_ZIMM,
        SRC_B_EIGHT     // jal link value is pc + 8
    } src_b_e;

endpackage

// ==== hdl/inst_latch.sv ====
`include "id_macros.svh"

module inst_latch
    import id_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_id,
    input  logic              stall_ex,
    input  logic              fetch_valid,
    input  logic [`WORD_W-1:0] fetch_pc,
    input  logic [`WORD_W-1:0] inst_rdata,
    output logic              valid,
    output logic [`WORD_W-1:0] pc,
    output instr_u            inst
);

    logic              held;
    logic [`WORD_W-1:0] hold_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            held  <= 1'b0;
        end else if (stall_id && !stall_ex) begin
            valid <= 1'b0;  // bubble into EX
            held  <= 1'b0;
        end else if (!stall_id) begin
            valid <= fetch_valid;
            held  <= 1'b0;
        end else if (valid && !held) begin
            held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_id) begin
            pc <= fetch_pc;
        end
        // grab the word once, memory output may move on
        if (stall_id && stall_ex && !held) begin
            hold_buf <= inst_rdata;
        end
    end

    assign inst = valid ? (held ? hold_buf : inst_rdata) : '0;

    // held only ever covers a live instruction
    held_needs_valid: assert property (
        @(posedge clk) disable iff (rst) held |-> valid
    ) else $error("inst_latch: hold buffer in use without a valid instruction");

endmodule

// ==== hdl/operand_fetch.sv ====
`include "id_macros.svh"

module operand_fetch
    import id_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               valid,
    input  instr_u             inst,
    input  logic               ex_is_load,
    input  logic               ex_we,
    input  logic [`REG_AW-1:0] ex_waddr,
    input  logic [`WORD_W-1:0] ex_wdata,
    input  logic               mem_we,
    input  logic [`REG_AW-1:0] mem_waddr,
    input  logic [`WORD_W-1:0] mem_wdata,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_waddr,
    input  logic [`WORD_W-1:0] wb_wdata,
    output logic [`WORD_W-1:0] rs_data,
    output logic [`WORD_W-1:0] rt_data,
    output logic               stall_req
);

    logic [`WORD_W-1:0] regs [`NUM_REGS];
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic               ex_hit;

    assign rs = inst.r_fmt.rs;
    assign rt = inst.r_fmt.rt;

    always_ff @(posedge clk) begin
        if (wb_we && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    // youngest producer first
    function automatic logic [`WORD_W-1:0] read_fwd(
        input logic [`REG_AW-1:0] ra,
        input logic [`WORD_W-1:0] arr_data
    );
        if (ra == '0) begin
            return '0;
        end
        if (ex_we && ex_waddr == ra) begin
            return ex_wdata;
        end
        if (mem_we && mem_waddr == ra) begin
            return mem_wdata;
        end
        if (wb_we && wb_waddr == ra) begin
            return wb_wdata;
        end
        return arr_data;
    endfunction

    always_comb begin
        rs_data = read_fwd(rs, regs[rs]);
        rt_data = read_fwd(rt, regs[rt]);
    end

    // load data not back until MEM, so wait a cycle
    assign ex_hit    = ex_is_load && ex_we && ex_waddr != '0;
    assign stall_req = valid && ex_hit && (ex_waddr == rs || ex_waddr == rt);

    // r0 stays zero whatever the producers drive
    zero_reg_reads_zero: assert property (
        @(posedge clk) disable iff (rst)
            (rs != '0 || rs_data == '0) && (rt != '0 || rt_data == '0)
    ) else $error("operand_fetch: register 0 read back nonzero");

endmodule

// ==== hdl/inst_decoder.sv ====
`include "id_macros.svh"

module inst_decoder
    import id_pkg::*;
(
    input  logic               valid,
    input  instr_u             inst,
    output alu_op_e            alu_op,
    output src_a_e             src_a,
    output src_b_e             src_b,
    output logic               mem_en,
    output logic               mem_we,
    output logic               rf_we,
    output logic [`REG_AW-1:0] rf_waddr,
    output logic               load_sel
);

    logic               known;
    logic               ok;
    alu_op_e            op_d;
    src_a_e             a_d;
    src_b_e             b_d;
    logic               mem_en_d;
    logic               mem_we_d;
    logic               wr_d;
    logic [`REG_AW-1:0] waddr_d;
    logic               lw_d;

    always_comb begin
        known    = 1'b1;
        op_d     = ALU_ADD;
        a_d      = SRC_A_RS;
        b_d      = SRC_B_RT;
        mem_en_d = 1'b0;
        mem_we_d = 1'b0;
        wr_d     = 1'b0;
        waddr_d  = '0;
        lw_d     = 1'b0;
        case (inst.r_fmt.opcode)
            `OP_SPECIAL: begin
                wr_d    = 1'b1;
                waddr_d = inst.r_fmt.rd;
                case (inst.r_fmt.funct)
                    `FN_ADDU: op_d = ALU_ADD;
                    `FN_SUBU: op_d = ALU_SUB;
                    `FN_AND:  op_d = ALU_AND;
                    `FN_OR:   op_d = ALU_OR;
                    `FN_XOR:  op_d = ALU_XOR;
                    `FN_NOR:  op_d = ALU_NOR;
                    `FN_SLT:  op_d = ALU_SLT;
                    `FN_SLTU: op_d = ALU_SLTU;
                    `FN_SLL: begin
                        op_d = ALU_SLL;
                        a_d  = SRC_A_SHAMT;
                    end
                    `FN_SRL: begin
                        op_d = ALU_SRL;
                        a_d  = SRC_A_SHAMT;
                    end
                    `FN_SRA: begin
                        op_d = ALU_SRA;
                        a_d  = SRC_A_SHAMT;
                    end
                    `FN_JR: begin
                        wr_d    = 1'b0; // target handled by branch unit
                        waddr_d = '0;
                    end
                    default: known = 1'b0;
                endcase
            end
            `OP_REGIMM: begin
                known = inst.i_fmt.rt == `RT_BLTZ || inst.i_fmt.rt == `RT_BGEZ;
            end
            `OP_J, `OP_BEQ, `OP_BNE: known = 1'b1;
            `OP_JAL: begin
                a_d     = SRC_A_PC;
                b_d     = SRC_B_EIGHT;
                wr_d    = 1'b1;
                waddr_d = `LINK_REG;
            end
            `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_LUI: begin
                b_d     = SRC_B_SIMM;
                wr_d    = 1'b1;
                waddr_d = inst.i_fmt.rt;
                case (inst.i_fmt.opcode)
                    `OP_SLTI:  op_d = ALU_SLT;
                    `OP_SLTIU: op_d = ALU_SLTU;
                    `OP_LUI:   op_d = ALU_LUI;
                    default:   op_d = ALU_ADD;
                endcase
            end
            `OP_ANDI, `OP_ORI, `OP_XORI: begin
                b_d     = SRC_B_ZIMM;   // logical ops zero extend
                wr_d    = 1'b1;
                waddr_d = inst.i_fmt.rt;
                case (inst.i_fmt.opcode)
                    `OP_ANDI: op_d = ALU_AND;
                    `OP_ORI:  op_d = ALU_OR;
                    default:  op_d = ALU_XOR;
                endcase
            end
            `OP_LW: begin
                b_d      = SRC_B_SIMM;
                mem_en_d = 1'b1;
                wr_d     = 1'b1;
                waddr_d  = inst.i_fmt.rt;
                lw_d     = 1'b1;
            end
            `OP_SW: begin
                b_d      = SRC_B_SIMM;
                mem_en_d = 1'b1;
                mem_we_d = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    assign ok       = valid && known;
    assign alu_op   = ok ? op_d : ALU_ADD;
    assign src_a    = ok ? a_d : SRC_A_RS;
    assign src_b    = ok ? b_d : SRC_B_RT;
    assign mem_en   = ok && mem_en_d;
    assign mem_we   = ok && mem_we_d;
    assign rf_we    = ok && wr_d;
    assign rf_waddr = ok ? waddr_d : '0;
    assign load_sel = ok && lw_d;

endmodule

// ==== hdl/branch_unit.sv ====
`include "id_macros.svh"

module branch_unit
    import id_pkg::*;
(
    input  logic               valid,
    input  logic [`WORD_W-1:0] pc,
    input  instr_u             inst,
    input  logic [`WORD_W-1:0] rs_data,
    input  logic [`WORD_W-1:0] rt_data,
    output logic               br_taken,
    output logic [`WORD_W-1:0] br_target
);

    logic [`WORD_W-1:0] pc_next;
    logic [`WORD_W-1:0] br_off;
    logic [`WORD_W-1:0] jmp_tgt;
    logic               take;
    logic [`WORD_W-1:0] tgt;

    assign pc_next = pc + `WORD_W'(`PC_STEP);
    assign br_off  = {{14{inst.i_fmt.imm[15]}}, inst.i_fmt.imm, 2'b00};
    assign jmp_tgt = {pc_next[`WORD_W-1 -: 4], inst.j_fmt.index, 2'b00};   // same 256MB region

    always_comb begin
        take = 1'b0;
        tgt  = pc_next + br_off;
        case (inst.i_fmt.opcode)
            `OP_BEQ: take = rs_data == rt_data;
            `OP_BNE: take = rs_data != rt_data;
            `OP_REGIMM: begin
                if (inst.i_fmt.rt == `RT_BGEZ) begin
                    take = !rs_data[`WORD_W-1];
                end else if (inst.i_fmt.rt == `RT_BLTZ) begin
                    take = rs_data[`WORD_W-1];
                end
            end
            `OP_J, `OP_JAL: begin
                take = 1'b1;
                tgt  = jmp_tgt;
            end
            `OP_SPECIAL: begin
                if (inst.r_fmt.funct == `FN_JR) begin
                    take = 1'b1;
                    tgt  = rs_data;     // forwarded rs
                end
            end
            default: take = 1'b0;
        endcase
    end

    assign br_taken  = valid && take;
    assign br_target = br_taken ? tgt : '0;

endmodule

// ==== hdl/id_stage.sv ====
`include "id_macros.svh"

module id_stage
    import id_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               stall_id,
    input  logic               stall_ex,
    input  logic               fetch_valid,
    input  logic [`WORD_W-1:0] fetch_pc,
    input  logic [`WORD_W-1:0] inst_rdata,
    input  logic               ex_we,
    input  logic [`REG_AW-1:0] ex_waddr,
    input  logic [`WORD_W-1:0] ex_wdata,
    input  logic               mem_we,
    input  logic [`REG_AW-1:0] mem_waddr,
    input  logic [`WORD_W-1:0] mem_wdata,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_waddr,
    input  logic [`WORD_W-1:0] wb_wdata,
    input  logic               ex_is_load,
    output logic [`WORD_W-1:0] pc,
    output instr_u             inst,
    output alu_op_e            alu_op,
    output src_a_e             src_a,
    output src_b_e             src_b,
    output logic               mem_en,
    output logic               mem_wr,
    output logic               rf_we,
    output logic [`REG_AW-1:0] rf_waddr,
    output logic               load_sel,
    output logic [`WORD_W-1:0] rs_data,
    output logic [`WORD_W-1:0] rt_data,
    output logic               br_taken,
    output logic [`WORD_W-1:0] br_target,
    output logic               stall_req
);

    logic valid;

    inst_latch latch_i (
        .clk         (clk),
        .rst         (rst),
        .stall_id    (stall_id),
        .stall_ex    (stall_ex),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .inst_rdata  (inst_rdata),
        .valid       (valid),
        .pc          (pc),
        .inst        (inst)
    );

    operand_fetch opf_i (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .inst       (inst),
        .ex_is_load (ex_is_load),
        .ex_we      (ex_we),
        .ex_waddr   (ex_waddr),
        .ex_wdata   (ex_wdata),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .wb_we      (wb_we),
        .wb_waddr   (wb_waddr),
        .wb_wdata   (wb_wdata),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .stall_req  (stall_req)
    );

    inst_decoder dec_i (
        .valid    (valid),
        .inst     (inst),
        .alu_op   (alu_op),
        .src_a    (src_a),
        .src_b    (src_b),
        .mem_en   (mem_en),
        .mem_we   (mem_wr),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .load_sel (load_sel)
    );

    branch_unit bru_i (
        .valid     (valid),
        .pc        (pc),
        .inst      (inst),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

// ==== dv/id_model.sv ====
`include "id_macros.svh"

module id_model
    import id_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               stall_id,
    input  logic               stall_ex,
    input  logic               fetch_valid,
    input  logic [`WORD_W-1:0] fetch_pc,
    input  logic [`WORD_W-1:0] inst_rdata,
    input  logic               ex_is_load,
    input  logic               ex_we,
    input  logic [`REG_AW-1:0] ex_waddr,
    input  logic [`WORD_W-1:0] ex_wdata,
    input  logic               mem_we,
    input  logic [`REG_AW-1:0] mem_waddr,
    input  logic [`WORD_W-1:0] mem_wdata,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_waddr,
    input  logic [`WORD_W-1:0] wb_wdata,
    output logic               valid,
    output logic [`WORD_W-1:0] pc,
    output instr_u             inst,
    output alu_op_e            alu_op,
    output src_a_e             src_a,
    output src_b_e             src_b,
    output logic               mem_en,
    output logic               mem_wr,
    output logic               rf_we,
    output logic [`REG_AW-1:0] rf_waddr,
    output logic               load_sel,
    output logic [`WORD_W-1:0] rs_data,
    output logic [`WORD_W-1:0] rt_data,
    output logic               br_taken,
    output logic [`WORD_W-1:0] br_target,
    output logic               stall_req
);
    timeunit 1ns;
    timeprecision 100ps;

    logic               frozen;
    logic [`WORD_W-1:0] saved_word;
    logic [`WORD_W-1:0] regs [`NUM_REGS];
    logic [`WORD_W-1:0] seq_pc;
    alu_op_e            op_r;
    alu_op_e            op_i;
    src_b_e             b_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid  <= 1'b0;
            frozen <= 1'b0;
        end else begin
            case ({stall_id, stall_ex})
                2'b10: begin
                    valid  <= 1'b0;
                    frozen <= 1'b0;
                end
                2'b11: begin
                    if (!frozen) begin
                        saved_word <= inst_rdata;   // first stalled cycle only
                        frozen     <= valid;
                    end
                end
                default: begin
                    valid  <= fetch_valid;
                    pc     <= fetch_pc;
                    frozen <= 1'b0;
                end
            endcase
        end
        if (wb_we && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    assign inst = valid ? (frozen ? saved_word : inst_rdata) : '0;

    // later assignments are younger stages
    function automatic logic [`WORD_W-1:0] operand(input logic [`REG_AW-1:0] a);
        logic [`WORD_W-1:0] d;
        d = regs[a];
        if (wb_we && wb_waddr == a) d = wb_wdata;
        if (mem_we && mem_waddr == a) d = mem_wdata;
        if (ex_we && ex_waddr == a) d = ex_wdata;
        if (a == '0) d = '0;
        return d;
    endfunction

    function automatic logic r_alu(input logic [5:0] fn, output alu_op_e op);
        op = ALU_ADD;
        case (fn)
            `FN_ADDU: op = ALU_ADD;
            `FN_SUBU: op = ALU_SUB;
            `FN_AND:  op = ALU_AND;
            `FN_OR:   op = ALU_OR;
            `FN_XOR:  op = ALU_XOR;
            `FN_NOR:  op = ALU_NOR;
            `FN_SLT:  op = ALU_SLT;
            `FN_SLTU: op = ALU_SLTU;
            `FN_SLL:  op = ALU_SLL;
            `FN_SRL:  op = ALU_SRL;
            `FN_SRA:  op = ALU_SRA;
            default:  return 1'b0;  // jr lands here too, no write-back
        endcase
        return 1'b1;
    endfunction

    function automatic logic imm_alu(input logic [5:0] opc, output alu_op_e op,
                                     output src_b_e sb);
        op = ALU_ADD;
        sb = SRC_B_SIMM;
        case (opc)
            `OP_ADDIU: op = ALU_ADD;
            `OP_SLTI:  op = ALU_SLT;
            `OP_SLTIU: op = ALU_SLTU;
            `OP_LUI:   op = ALU_LUI;
            `OP_ANDI: begin
                op = ALU_AND;
                sb = SRC_B_ZIMM;
            end
            `OP_ORI: begin
                op = ALU_OR;
                sb = SRC_B_ZIMM;
            end
            `OP_XORI: begin
                op = ALU_XOR;
                sb = SRC_B_ZIMM;
            end
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    always_comb begin
        rs_data   = operand(inst.r_fmt.rs);
        rt_data   = operand(inst.r_fmt.rt);
        stall_req = valid && ex_is_load && ex_we && ex_waddr != '0 &&
                    (ex_waddr == inst.r_fmt.rs || ex_waddr == inst.r_fmt.rt);
    end

    always_comb begin
        alu_op   = ALU_ADD;
        src_a    = SRC_A_RS;
        src_b    = SRC_B_RT;
        mem_en   = 1'b0;
        mem_wr   = 1'b0;
        rf_we    = 1'b0;
        rf_waddr = '0;
        load_sel = 1'b0;
        op_r     = ALU_ADD;
        op_i     = ALU_ADD;
        b_i      = SRC_B_RT;
        if (valid) begin
            case (inst.r_fmt.opcode)
                `OP_SPECIAL: begin
                    if (r_alu(inst.r_fmt.funct, op_r)) begin
                        alu_op   = op_r;
                        rf_we    = 1'b1;
                        rf_waddr = inst.r_fmt.rd;
                        if (op_r inside {ALU_SLL, ALU_SRL, ALU_SRA}) src_a = SRC_A_SHAMT;
                    end
                end
                `OP_JAL: begin
                    src_a    = SRC_A_PC;
                    src_b    = SRC_B_EIGHT;
                    rf_we    = 1'b1;
                    rf_waddr = `LINK_REG;
                end
                `OP_LW: begin
                    src_b    = SRC_B_SIMM;
                    mem_en   = 1'b1;
                    rf_we    = 1'b1;
                    rf_waddr = inst.i_fmt.rt;
                    load_sel = 1'b1;
                end
                `OP_SW: begin
                    src_b  = SRC_B_SIMM;
                    mem_en = 1'b1;
                    mem_wr = 1'b1;
                end
                default: begin
                    if (imm_alu(inst.i_fmt.opcode, op_i, b_i)) begin
                        alu_op   = op_i;
                        src_b    = b_i;
                        rf_we    = 1'b1;
                        rf_waddr = inst.i_fmt.rt;
                    end
                end
            endcase
        end
    end

    always_comb begin
        seq_pc    = pc + `WORD_W'(`PC_STEP);
        br_taken  = 1'b0;
        br_target = '0;
        if (valid) begin
            case (inst.i_fmt.opcode)
                `OP_BEQ: br_taken = rs_data == rt_data;
                `OP_BNE: br_taken = rs_data != rt_data;
                `OP_REGIMM: br_taken = (inst.i_fmt.rt == `RT_BGEZ && !rs_data[`WORD_W-1]) ||
                                       (inst.i_fmt.rt == `RT_BLTZ && rs_data[`WORD_W-1]);
                `OP_J, `OP_JAL: br_taken = 1'b1;
                `OP_SPECIAL: br_taken = inst.r_fmt.funct == `FN_JR;
                default: br_taken = 1'b0;
            endcase
            if (br_taken) begin
                if (inst.j_fmt.opcode == `OP_J || inst.j_fmt.opcode == `OP_JAL) begin
                    br_target = {seq_pc[`WORD_W-1 -: 4], inst.j_fmt.index, 2'b00};
                end else if (inst.r_fmt.opcode == `OP_SPECIAL) begin
                    br_target = rs_data;
                end else begin
                    br_target = seq_pc + {{14{inst.i_fmt.imm[15]}}, inst.i_fmt.imm, 2'b00};
                end
            end
        end
    end

endmodule

// ==== dv/id_stage_tb.sv ====
`include "id_macros.svh"

module id_stage_tb
    import id_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned SEED        = 32'h58e0bbaa;
    localparam int          RST_CYCLES  = 5;
    localparam int          STIM_CYCLES = 1500;
    localparam int          MAX_CYCLES  = STIM_CYCLES + 500;   // reset, register init, margin

    localparam logic [5:0] R_FUNCTS [12] = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR,
        `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA, `FN_JR};
    localparam logic [5:0] I_OPS [9] = '{`OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_SLTI,
        `OP_SLTIU, `OP_LUI, `OP_LW, `OP_SW};

    logic               clk;
    logic               rst;
    logic               stall_id;
    logic               stall_ex;
    logic               fetch_valid;
    logic [`WORD_W-1:0] fetch_pc;
    logic [`WORD_W-1:0] inst_rdata;
    logic               ex_we;
    logic [`REG_AW-1:0] ex_waddr;
    logic [`WORD_W-1:0] ex_wdata;
    logic               mem_we;
    logic [`REG_AW-1:0] mem_waddr;
    logic [`WORD_W-1:0] mem_wdata;
    logic               wb_we;
    logic [`REG_AW-1:0] wb_waddr;
    logic [`WORD_W-1:0] wb_wdata;
    logic               ex_is_load;
    logic [`WORD_W-1:0] pc;
    instr_u             inst;
    alu_op_e            alu_op;
    src_a_e             src_a;
    src_b_e             src_b;
    logic               mem_en;
    logic               mem_wr;
    logic               rf_we;
    logic [`REG_AW-1:0] rf_waddr;
    logic               load_sel;
    logic [`WORD_W-1:0] rs_data;
    logic [`WORD_W-1:0] rt_data;
    logic               br_taken;
    logic [`WORD_W-1:0] br_target;
    logic               stall_req;

    logic               exp_valid;
    logic [`WORD_W-1:0] exp_pc;
    instr_u             exp_inst;
    alu_op_e            exp_alu_op;
    src_a_e             exp_src_a;
    src_b_e             exp_src_b;
    logic               exp_mem_en;
    logic               exp_mem_we;
    logic               exp_rf_we;
    logic [`REG_AW-1:0] exp_rf_waddr;
    logic               exp_load_sel;
    logic [`WORD_W-1:0] exp_rs_data;
    logic [`WORD_W-1:0] exp_rt_data;
    logic               exp_br_taken;
    logic [`WORD_W-1:0] exp_br_target;
    logic               exp_stall_req;

    logic        checking = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int unsigned stall_left = 0;

    id_stage dut_i (.*);

    id_model model_i (
        .valid     (exp_valid),
        .pc        (exp_pc),
        .inst      (exp_inst),
        .alu_op    (exp_alu_op),
        .src_a     (exp_src_a),
        .src_b     (exp_src_b),
        .mem_en    (exp_mem_en),
        .mem_wr    (exp_mem_we),
        .rf_we     (exp_rf_we),
        .rf_waddr  (exp_rf_waddr),
        .load_sel  (exp_load_sel),
        .rs_data   (exp_rs_data),
        .rt_data   (exp_rt_data),
        .br_taken  (exp_br_taken),
        .br_target (exp_br_target),
        .stall_req (exp_stall_req),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [`WORD_W-1:0] rand_instr();
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [15:0]        imm;
        int unsigned        pick;
        rs   = 5'($urandom);
        rt   = 5'($urandom);
        imm  = 16'($urandom);
        pick = $urandom % 28;
        if (pick < 12) return {`OP_SPECIAL, rs, rt, 5'($urandom), 5'($urandom), R_FUNCTS[4'(pick)]};
        if (pick < 21) return {I_OPS[4'(pick - 12)], rs, rt, imm};
        if ($urandom % 2 == 0) rt = rs;     // equal operands, beq taken
        case (pick)
            21: return {`OP_BEQ, rs, rt, imm};
            22: return {`OP_BNE, rs, rt, imm};
            23: return {`OP_REGIMM, rs, `RT_BLTZ, imm};
            24: return {`OP_REGIMM, rs, `RT_BGEZ, imm};
            25: return {`OP_J, 26'($urandom)};
            26: return {`OP_JAL, 26'($urandom)};
            default: return $urandom;       // mostly not decoded
        endcase
    endfunction

    // aim producers at the source registers often
    function automatic logic [`REG_AW-1:0] pick_addr(input instr_u w);
        case ($urandom % 4)
            0: return w.r_fmt.rs;
            1: return w.r_fmt.rt;
            default: return 5'($urandom);
        endcase
    endfunction

    task automatic idle_inputs();
        stall_id    = 1'b0;
        stall_ex    = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        inst_rdata  = '0;
        ex_we       = 1'b0;
        ex_waddr    = '0;
        ex_wdata    = '0;
        mem_we      = 1'b0;
        mem_waddr   = '0;
        mem_wdata   = '0;
        wb_we       = 1'b0;
        wb_waddr    = '0;
        wb_wdata    = '0;
        ex_is_load  = 1'b0;
    endtask

    task automatic pick_stalls();
        if (stall_left > 0) begin
            stall_left--;
        end else begin
            case ($urandom % 10)
                0, 1: begin
                    stall_id   = 1'b1;
                    stall_ex   = 1'b1;
                    stall_left = $urandom % 4;
                end
                2: begin
                    stall_id = 1'b1;
                    stall_ex = 1'b0;
                end
                default: begin
                    stall_id = 1'b0;
                    stall_ex = 1'b0;
                end
            endcase
        end
    endtask

    task automatic drive_cycle();
        instr_u w;
        w           = rand_instr();
        inst_rdata  = w;
        fetch_valid = ($urandom % 8) != 0;
        fetch_pc    = $urandom & ~32'h3;
        pick_stalls();
        ex_we      = 1'($urandom);
        ex_waddr   = pick_addr(w);
        ex_wdata   = $urandom;
        ex_is_load = ($urandom % 3) == 0;
        mem_we     = 1'($urandom);
        mem_waddr  = pick_addr(w);
        mem_wdata  = $urandom;
        wb_we      = 1'($urandom);
        wb_waddr   = pick_addr(w);
        wb_wdata   = $urandom;
        if ($urandom % 8 == 0) begin
            ex_we     = 1'b1;     // all three on one register
            mem_we    = 1'b1;
            wb_we     = 1'b1;
            mem_waddr = ex_waddr;
            wb_waddr  = ex_waddr;
        end
    endtask

    task automatic check_val(input string name, input logic [`WORD_W-1:0] got,
                             input logic [`WORD_W-1:0] exp);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("** Error: %s expected %h, got %h at %0t", name, exp, got, $time);
            end
    endtask

    task automatic check_outputs();
        if (exp_valid) check_val("pc", pc, exp_pc);
        check_val("inst", 32'(inst), 32'(exp_inst));
        check_val("alu_op", 32'(alu_op), 32'(exp_alu_op));
        check_val("src_a", 32'(src_a), 32'(exp_src_a));
        check_val("src_b", 32'(src_b), 32'(exp_src_b));
        check_val("mem_en", 32'(mem_en), 32'(exp_mem_en));
        check_val("mem_wr", 32'(mem_wr), 32'(exp_mem_we));
        check_val("rf_we", 32'(rf_we), 32'(exp_rf_we));
        check_val("rf_waddr", 32'(rf_waddr), 32'(exp_rf_waddr));
        check_val("load_sel", 32'(load_sel), 32'(exp_load_sel));
        check_val("rs_data", rs_data, exp_rs_data);
        check_val("rt_data", rt_data, exp_rt_data);
        check_val("br_taken", 32'(br_taken), 32'(exp_br_taken));
        check_val("br_target", br_target, exp_br_target);
        check_val("stall_req", 32'(stall_req), 32'(exp_stall_req));
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (checking) check_outputs();
    end

    initial begin
        void'($urandom(SEED));
        idle_inputs();
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        checking = 1'b1;
        for (int r = 1; r < `NUM_REGS; r++) begin
            @(posedge clk);
            #1;
            wb_we    = 1'b1;
            wb_waddr = 5'(r);
            wb_wdata = $urandom;
        end
        for (int i = 0; i < STIM_CYCLES; i++) begin
            @(posedge clk);
            #1;
            drive_cycle();
        end
        @(posedge clk);
        #1 idle_inputs();
        @(negedge clk);
        @(posedge clk);
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== id_stage.f ====
+incdir+include
hdl/id_pkg.sv
hdl/inst_latch.sv
hdl/operand_fetch.sv
hdl/inst_decoder.sv
hdl/branch_unit.sv
hdl/id_stage.sv
dv/id_model.sv
dv/id_stage_tb.sv

// ==== Makefile ====
SRCS = id_stage.f include/id_macros.svh $(wildcard hdl/*.sv) $(wildcard dv/*.sv)

.PHONY: run clean

run: obj_dir/Vid_stage_tb
	@out=$$(./obj_dir/Vid_stage_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

obj_dir/Vid_stage_tb: $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module id_stage_tb -f id_stage.f

clean:
	rm -rf obj_dir
